/* soc_cfg.svh */
// widths, depths and address map of the peripheral subsystem, included by RTL and testbench
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// bus geometry
`define SOC_DW          32                      // data word
`define SOC_AW          12                      // master word address
`define SOC_SW          4                       // byte selects
`define SOC_SLV_W       3                       // top address bits pick the slave
`define SOC_OFF_W       (`SOC_AW - `SOC_SLV_W)  // 9, word offset inside a slave

// peripheral sizes
`define SOC_RAM_AW      8                       // 256 words
`define SOC_GPIO_W      8
`define SOC_EXT_INT_NUM 3
`define SOC_TIMER_W     32

// slave map, indices 5 to 7 answer with zero
`define SOC_ID_RAM      0
`define SOC_ID_GPIO     1
`define SOC_ID_EXT      2
`define SOC_ID_TIMER    3
`define SOC_ID_INTC     4
`define SOC_SLAVE_NUM   5

// interrupt controller inputs, bit 0 timer and bit 1 external
`define SOC_IRQ_NUM     2

`endif

/* soc_bus_pkg.sv */
// bus-side types shared by the interconnect, the slaves and the testbench
`include "soc_cfg.svh"

package soc_bus_pkg;

	// one data word on the bus
	typedef logic [`SOC_DW-1:0] word_t;

	// word address driven by the master
	typedef logic [`SOC_AW-1:0] wadr_t;

	// byte enables, one per lane
	typedef logic [`SOC_SW-1:0] sel_t;

	// slave index taken from the top address bits
	typedef logic [`SOC_SLV_W-1:0] slv_t;

	// word offset passed to every slave
	typedef logic [`SOC_OFF_W-1:0] off_t;

endpackage

/* soc_periph_pkg.sv */
// peripheral-side types for the GPIO, timer and interrupt blocks
`include "soc_cfg.svh"

package soc_periph_pkg;

	// GPIO output pins
	typedef logic [`SOC_GPIO_W-1:0] gpio_t;

	// external interrupt lines
	typedef logic [`SOC_EXT_INT_NUM-1:0] ext_vec_t;

	// interrupt controller inputs
	typedef logic [`SOC_IRQ_NUM-1:0] irq_vec_t;

	// timer counter and compare value
	typedef logic [`SOC_TIMER_W-1:0] tcount_t;

	// register select inside a small peripheral, four registers
	typedef logic [1:0] reg_off_t;

endpackage

/* soc_interconnect.sv */
// single-master wishbone decoder, routes stb by slave index and muxes ack and read data back
`timescale 1ns/1ps
`include "soc_cfg.svh"

module soc_interconnect (
	input  logic                                 clk,
	input  logic                                 arst_n_i,
	// master side
	input  logic                                 m_stb_i,
	input  logic                                 m_we_i,
	input  soc_bus_pkg::wadr_t                   m_adr_i,
	input  soc_bus_pkg::sel_t                    m_sel_i,
	input  soc_bus_pkg::word_t                   m_dat_i,
	output logic                                 m_ack_o,
	output soc_bus_pkg::word_t                   m_dat_o,
	// shared slave outputs
	output soc_bus_pkg::off_t                    s_off_o,
	output logic                                 s_we_o,
	output soc_bus_pkg::sel_t                    s_sel_o,
	output soc_bus_pkg::word_t                   s_dat_o,
	// per slave
	output logic [`SOC_SLAVE_NUM-1:0]            s_stb_o,
	input  logic [`SOC_SLAVE_NUM-1:0]            s_ack_i,
	input  soc_bus_pkg::word_t                   s_dat_i [`SOC_SLAVE_NUM]
);

	soc_bus_pkg::slv_t slv;
	logic              hit;
	logic              nm_ack_q;   // responder for unmapped indices

	assign slv     = m_adr_i[`SOC_AW-1:`SOC_OFF_W];
	assign s_off_o = m_adr_i[`SOC_OFF_W-1:0];
	assign hit     = (slv < soc_bus_pkg::slv_t'(`SOC_SLAVE_NUM));

	assign s_we_o  = m_we_i;
	assign s_sel_o = m_sel_i;
	assign s_dat_o = m_dat_i;

	always_comb begin
		for (int i = 0; i < `SOC_SLAVE_NUM; i++) begin
			s_stb_o[i] = m_stb_i && (slv == soc_bus_pkg::slv_t'(i));
		end
	end

	// unmapped access, writes dropped, reads see zero
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			nm_ack_q <= 1'b0;
		end else begin
			nm_ack_q <= m_stb_i && !hit && !nm_ack_q;
		end
	end

	assign m_ack_o = (|s_ack_i) || nm_ack_q;

	always_comb begin
		m_dat_o = '0;   // also the unmapped answer
		for (int i = 0; i < `SOC_SLAVE_NUM; i++) begin
			if (slv == soc_bus_pkg::slv_t'(i)) m_dat_o = s_dat_i[i];
		end
	end

endmodule

/* soc_ram.sv */
// on-chip data RAM slave, byte-lane writes and registered read data with ack
`timescale 1ns/1ps
`include "soc_cfg.svh"

module soc_ram (
	input  logic               clk,
	input  logic               arst_n_i,
	input  logic               stb_i,
	input  logic               we_i,
	input  soc_bus_pkg::off_t  off_i,
	input  soc_bus_pkg::sel_t  sel_i,
	input  soc_bus_pkg::word_t dat_i,
	output logic               ack_o,
	output soc_bus_pkg::word_t dat_o
);

	localparam int LANE_W = `SOC_DW / `SOC_SW;

	soc_bus_pkg::word_t     mem [2**`SOC_RAM_AW];
	logic [`SOC_RAM_AW-1:0] addr;
	logic                   acc;

	assign addr = off_i[`SOC_RAM_AW-1:0];   // upper offset bits alias
	assign acc  = stb_i && !ack_o;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= acc;
		end
	end

	always_ff @(posedge clk) begin
		if (acc && we_i) begin
			for (int b = 0; b < `SOC_SW; b++) begin
				if (sel_i[b]) mem[addr][b*LANE_W +: LANE_W] <= dat_i[b*LANE_W +: LANE_W];
			end
		end
		if (acc) dat_o <= mem[addr];   // old word on a write
	end

endmodule

/* soc_gpio.sv */
// output-only GPIO slave, one register driven onto the pins and readable over the bus
`timescale 1ns/1ps
`include "soc_cfg.svh"

module soc_gpio (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic                  stb_i,
	input  logic                  we_i,
	input  soc_bus_pkg::sel_t     sel_i,
	input  soc_bus_pkg::word_t    dat_i,
	output logic                  ack_o,
	output soc_bus_pkg::word_t    dat_o,
	output soc_periph_pkg::gpio_t gpio_o
);

	logic acc;

	assign acc = stb_i && !ack_o;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_o  <= 1'b0;
			gpio_o <= '0;
		end else begin
			ack_o <= acc;
			if (acc && we_i && sel_i[0]) begin
				gpio_o <= dat_i[`SOC_GPIO_W-1:0];   // low lane only
			end
		end
	end

	// every offset aliases the same register
	assign dat_o = soc_bus_pkg::word_t'(gpio_o);

endmodule

/* soc_timer.sv */
// compare timer slave, free counter wraps on match and raises a flag interrupt
`timescale 1ns/1ps
`include "soc_cfg.svh"

module soc_timer (
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  logic                     stb_i,
	input  logic                     we_i,
	input  soc_periph_pkg::reg_off_t off_i,
	input  soc_bus_pkg::word_t       dat_i,
	output logic                     ack_o,
	output soc_bus_pkg::word_t       dat_o,
	output logic                     irq_o
);

	soc_periph_pkg::tcount_t count_q;
	soc_periph_pkg::tcount_t cmp_q;
	logic                    run_q;
	logic                    ie_q;
	logic                    flag_q;
	logic                    acc;
	logic                    wr;
	logic                    match;

	assign acc   = stb_i && !ack_o;
	assign wr    = acc && we_i;
	assign match = run_q && (count_q == cmp_q);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_o   <= 1'b0;
			count_q <= '0;
			cmp_q   <= '0;
			run_q   <= 1'b0;
			ie_q    <= 1'b0;
			flag_q  <= 1'b0;
		end else begin
			ack_o <= acc;
			if (wr && off_i == 2'd0) begin
				run_q <= dat_i[0];
				ie_q  <= dat_i[1];
			end
			if (wr && off_i == 2'd1) cmp_q <= dat_i[`SOC_TIMER_W-1:0];
			if (match) count_q <= '0;
			else if (run_q) count_q <= count_q + soc_periph_pkg::tcount_t'(1);
			// a match in the same cycle wins over the clear
			if (match) flag_q <= 1'b1;
			else if (wr && off_i == 2'd3 && dat_i[0]) flag_q <= 1'b0;
		end
	end

	always_comb begin
		case (off_i)
			2'd0:    dat_o = soc_bus_pkg::word_t'({ie_q, run_q});
			2'd1:    dat_o = soc_bus_pkg::word_t'(cmp_q);
			2'd2:    dat_o = soc_bus_pkg::word_t'(count_q);   // read only
			default: dat_o = soc_bus_pkg::word_t'(flag_q);
		endcase
	end

	assign irq_o = flag_q && ie_q;

endmodule

/* soc_ext_int.sv */
// external interrupt slave, syncs the pins and latches rising edges into pending bits
`timescale 1ns/1ps
`include "soc_cfg.svh"

module soc_ext_int (
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  logic                     stb_i,
	input  logic                     we_i,
	input  soc_periph_pkg::reg_off_t off_i,
	input  soc_bus_pkg::word_t       dat_i,
	output logic                     ack_o,
	output soc_bus_pkg::word_t       dat_o,
	input  soc_periph_pkg::ext_vec_t ext_int_i,
	output logic                     irq_o
);

	soc_periph_pkg::ext_vec_t sync1_q, sync2_q, prev_q;
	soc_periph_pkg::ext_vec_t en_q;
	soc_periph_pkg::ext_vec_t pend_q;
	soc_periph_pkg::ext_vec_t rise;
	soc_periph_pkg::ext_vec_t clr;
	logic                     acc;
	logic                     wr;

	assign acc  = stb_i && !ack_o;
	assign wr   = acc && we_i;
	assign rise = sync2_q & ~prev_q;
	assign clr  = (wr && off_i == 2'd1) ? dat_i[`SOC_EXT_INT_NUM-1:0] : '0;   // write 1 to clear

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_o   <= 1'b0;
			sync1_q <= '0;
			sync2_q <= '0;
			prev_q  <= '0;
			en_q    <= '0;
			pend_q  <= '0;
		end else begin
			ack_o   <= acc;
			sync1_q <= ext_int_i;
			sync2_q <= sync1_q;
			prev_q  <= sync2_q;
			if (wr && off_i == 2'd0) en_q <= dat_i[`SOC_EXT_INT_NUM-1:0];
			pend_q <= (pend_q & ~clr) | rise;   // a new edge beats the clear
		end
	end

	always_comb begin
		case (off_i)
			2'd0:    dat_o = soc_bus_pkg::word_t'(en_q);
			2'd1:    dat_o = soc_bus_pkg::word_t'(pend_q);
			default: dat_o = '0;
		endcase
	end

	assign irq_o = |(pend_q & en_q);

endmodule

/* soc_int_ctrl.sv */
// interrupt controller slave, masks the timer and external lines into the system interrupt
`timescale 1ns/1ps
`include "soc_cfg.svh"

module soc_int_ctrl (
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  logic                     stb_i,
	input  logic                     we_i,
	input  soc_periph_pkg::reg_off_t off_i,
	input  soc_bus_pkg::word_t       dat_i,
	output logic                     ack_o,
	output soc_bus_pkg::word_t       dat_o,
	input  soc_periph_pkg::irq_vec_t irq_i,
	output logic                     int_o
);

	soc_periph_pkg::irq_vec_t mask_q;
	logic                     acc;

	assign acc = stb_i && !ack_o;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_o  <= 1'b0;
			mask_q <= '0;
		end else begin
			ack_o <= acc;
			if (acc && we_i && off_i == 2'd0) begin
				mask_q <= dat_i[`SOC_IRQ_NUM-1:0];
			end
		end
	end

	// offset 1 shows the lines before masking
	always_comb begin
		case (off_i)
			2'd0:    dat_o = soc_bus_pkg::word_t'(mask_q);
			2'd1:    dat_o = soc_bus_pkg::word_t'(irq_i);
			default: dat_o = '0;
		endcase
	end

	// lines are levels, the sources hold them until cleared
	assign int_o = |(irq_i & mask_q);

endmodule

/* soc_top.sv */
// peripheral subsystem top, reset sync plus bus, RAM, GPIO, timer and interrupt blocks
`timescale 1ns/1ps
`include "soc_cfg.svh"

module soc_top (
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  logic                     cpu_stb_i,
	input  logic                     cpu_we_i,
	input  soc_bus_pkg::wadr_t       cpu_adr_i,
	input  soc_bus_pkg::sel_t        cpu_sel_i,
	input  soc_bus_pkg::word_t       cpu_dat_i,
	output logic                     cpu_ack_o,
	output soc_bus_pkg::word_t       cpu_dat_o,
	input  soc_periph_pkg::ext_vec_t ext_int_i,
	output soc_periph_pkg::gpio_t    gpio_o,
	output logic                     sys_int_o
);

	logic [1:0]                rst_q;
	logic                      rst_n;      // released in sync with clk
	soc_bus_pkg::off_t         bus_off;
	soc_periph_pkg::reg_off_t  reg_off;
	logic                      bus_we;
	soc_bus_pkg::sel_t         bus_sel;
	soc_bus_pkg::word_t        bus_wdat;
	logic [`SOC_SLAVE_NUM-1:0] slv_stb;
	logic [`SOC_SLAVE_NUM-1:0] slv_ack;
	soc_bus_pkg::word_t        slv_rdat [`SOC_SLAVE_NUM];
	logic                      timer_irq;
	logic                      ext_irq;
	soc_periph_pkg::irq_vec_t  irq_vec;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rst_q <= 2'b00;
		end else begin
			rst_q <= {rst_q[0], 1'b1};
		end
	end

	assign rst_n   = rst_q[1];
	assign reg_off = bus_off[1:0];
	assign irq_vec = {ext_irq, timer_irq};   // bit 0 timer

	soc_interconnect u_ic (
		.clk(clk), .arst_n_i(rst_n),
		.m_stb_i(cpu_stb_i), .m_we_i(cpu_we_i), .m_adr_i(cpu_adr_i),
		.m_sel_i(cpu_sel_i), .m_dat_i(cpu_dat_i), .m_ack_o(cpu_ack_o), .m_dat_o(cpu_dat_o),
		.s_off_o(bus_off), .s_we_o(bus_we), .s_sel_o(bus_sel), .s_dat_o(bus_wdat),
		.s_stb_o(slv_stb), .s_ack_i(slv_ack), .s_dat_i(slv_rdat)
	);

	soc_ram u_ram (
		.clk(clk), .arst_n_i(rst_n), .stb_i(slv_stb[`SOC_ID_RAM]), .we_i(bus_we),
		.off_i(bus_off), .sel_i(bus_sel), .dat_i(bus_wdat),
		.ack_o(slv_ack[`SOC_ID_RAM]), .dat_o(slv_rdat[`SOC_ID_RAM])
	);

	soc_gpio u_gpio (
		.clk(clk), .arst_n_i(rst_n), .stb_i(slv_stb[`SOC_ID_GPIO]), .we_i(bus_we),
		.sel_i(bus_sel), .dat_i(bus_wdat), .ack_o(slv_ack[`SOC_ID_GPIO]),
		.dat_o(slv_rdat[`SOC_ID_GPIO]), .gpio_o(gpio_o)
	);

	soc_ext_int u_ext (
		.clk(clk), .arst_n_i(rst_n), .stb_i(slv_stb[`SOC_ID_EXT]), .we_i(bus_we),
		.off_i(reg_off), .dat_i(bus_wdat), .ack_o(slv_ack[`SOC_ID_EXT]),
		.dat_o(slv_rdat[`SOC_ID_EXT]), .ext_int_i(ext_int_i), .irq_o(ext_irq)
	);

	soc_timer u_timer (
		.clk(clk), .arst_n_i(rst_n), .stb_i(slv_stb[`SOC_ID_TIMER]), .we_i(bus_we),
		.off_i(reg_off), .dat_i(bus_wdat), .ack_o(slv_ack[`SOC_ID_TIMER]),
		.dat_o(slv_rdat[`SOC_ID_TIMER]), .irq_o(timer_irq)
	);

	soc_int_ctrl u_intc (
		.clk(clk), .arst_n_i(rst_n), .stb_i(slv_stb[`SOC_ID_INTC]), .we_i(bus_we),
		.off_i(reg_off), .dat_i(bus_wdat), .ack_o(slv_ack[`SOC_ID_INTC]),
		.dat_o(slv_rdat[`SOC_ID_INTC]), .irq_i(irq_vec), .int_o(sys_int_o)
	);

endmodule

/* tb_soc.sv */
// testbench for the peripheral subsystem, drives the external bus port and checks every block
`timescale 1ns/1ps
`include "soc_cfg.svh"

module tb_soc;

	localparam int BUS_TIMEOUT = 20;    // cycles allowed for an ack
	localparam int IRQ_TIMEOUT = 200;   // cycles allowed for sys_int_o to rise
	localparam int RAM_WRITES  = 24;

	logic                     clk;
	logic                     arst_n_i;
	logic                     cpu_stb_i;
	logic                     cpu_we_i;
	soc_bus_pkg::wadr_t       cpu_adr_i;
	soc_bus_pkg::sel_t        cpu_sel_i;
	soc_bus_pkg::word_t       cpu_dat_i;
	logic                     cpu_ack_o;
	soc_bus_pkg::word_t       cpu_dat_o;
	soc_periph_pkg::ext_vec_t ext_int_i;
	soc_periph_pkg::gpio_t    gpio_o;
	logic                     sys_int_o;

	int                 errors;
	int                 checks;
	logic [31:0]        lcg_state;
	soc_bus_pkg::word_t ram_model [2**`SOC_RAM_AW];   // expected RAM contents
	bit                 ram_valid [2**`SOC_RAM_AW];

	soc_top u_dut (
		.clk(clk), .arst_n_i(arst_n_i),
		.cpu_stb_i(cpu_stb_i), .cpu_we_i(cpu_we_i), .cpu_adr_i(cpu_adr_i),
		.cpu_sel_i(cpu_sel_i), .cpu_dat_i(cpu_dat_i),
		.cpu_ack_o(cpu_ack_o), .cpu_dat_o(cpu_dat_o),
		.ext_int_i(ext_int_i), .gpio_o(gpio_o), .sys_int_o(sys_int_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;   // 4 ns period
	end

	// the addressed slave answers in the cycle after it samples stb
	ack_follows_stb: assert property (@(posedge clk) disable iff (!arst_n_i)
		$rose(cpu_stb_i) |=> cpu_ack_o)
		else begin
			errors++;
			$display("ack did not follow stb by one cycle at %0t", $time);
		end

	single_ack: assert property (@(posedge clk) disable iff (!arst_n_i)
		cpu_ack_o |=> !cpu_ack_o)
		else begin
			errors++;
			$display("ack stayed high for two cycles at %0t", $time);
		end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// slave index in the top bits, word offset below
	function automatic soc_bus_pkg::wadr_t adr_of(input int slv, input int off);
		return {slv[`SOC_SLV_W-1:0], off[`SOC_OFF_W-1:0]};
	endfunction

	function automatic soc_bus_pkg::word_t merge_bytes(input soc_bus_pkg::word_t old_w,
		input soc_bus_pkg::word_t new_w, input soc_bus_pkg::sel_t sel);
		soc_bus_pkg::word_t res;
		res = old_w;
		for (int b = 0; b < `SOC_SW; b++) begin
			if (sel[b]) res[b*8 +: 8] = new_w[b*8 +: 8];   // only enabled lanes
		end
		return res;
	endfunction

	task automatic check_word(input string name, input soc_bus_pkg::word_t exp,
		input soc_bus_pkg::word_t act);
		checks++;
		assert (act === exp)
		else begin
			errors++;
			$display("Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic bus_cycle(input logic we, input soc_bus_pkg::wadr_t adr,
		input soc_bus_pkg::sel_t sel, input soc_bus_pkg::word_t wdat,
		output soc_bus_pkg::word_t rdat);
		int n;
		@(negedge clk);
		cpu_stb_i = 1'b1;
		cpu_we_i  = we;
		cpu_adr_i = adr;
		cpu_sel_i = sel;
		cpu_dat_i = wdat;
		rdat      = '0;
		n         = 0;
		while (!cpu_ack_o && n < BUS_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (cpu_ack_o) begin
			rdat = cpu_dat_o;   // valid together with ack
		end else begin
			errors++;
			$display("bus access to address %h was never acknowledged", adr);
		end
		@(negedge clk);   // ack has been seen on a rising edge
		cpu_stb_i = 1'b0;
		cpu_we_i  = 1'b0;
	endtask

	task automatic bus_write(input soc_bus_pkg::wadr_t adr, input soc_bus_pkg::sel_t sel,
		input soc_bus_pkg::word_t dat);
		soc_bus_pkg::word_t unused_rd;
		bus_cycle(1'b1, adr, sel, dat, unused_rd);
	endtask

	task automatic bus_read(input soc_bus_pkg::wadr_t adr, output soc_bus_pkg::word_t dat);
		bus_cycle(1'b0, adr, 4'hF, '0, dat);
	endtask

	task automatic wait_sys_int(input string what);
		int n;
		n = 0;
		while (!sys_int_o && n < IRQ_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!sys_int_o) begin
			errors++;
			$display("sys_int_o never rose during the %s test", what);
		end
	endtask

	initial begin
		soc_bus_pkg::word_t     rd;
		soc_bus_pkg::word_t     wd;
		soc_bus_pkg::sel_t      sel;
		logic [`SOC_RAM_AW-1:0] a;
		logic [31:0]            r;
		errors    = 0;
		checks    = 0;
		lcg_state = 32'd26;
		arst_n_i  = 1'b0;
		cpu_stb_i = 1'b0;
		cpu_we_i  = 1'b0;
		cpu_adr_i = '0;
		cpu_sel_i = '0;
		cpu_dat_i = '0;
		ext_int_i = '0;
		for (int i = 0; i < 2**`SOC_RAM_AW; i++) ram_valid[i] = 1'b0;
		repeat (16) @(negedge clk);
		arst_n_i = 1'b1;
		repeat (4) @(negedge clk);   // internal reset sync releases

		check_word("reset ack", '0, soc_bus_pkg::word_t'(cpu_ack_o));
		check_word("reset gpio", '0, soc_bus_pkg::word_t'(gpio_o));
		check_word("reset sys_int", '0, soc_bus_pkg::word_t'(sys_int_o));

		// random byte-lane writes, model keeps the merged words
		for (int i = 0; i < RAM_WRITES; i++) begin
			r = next_rand();
			a = r[30:23];
			if (!ram_valid[a]) begin
				wd = next_rand();
				bus_write(adr_of(`SOC_ID_RAM, int'(a)), 4'hF, wd);
				ram_model[a] = wd;
				ram_valid[a] = 1'b1;
			end
			wd  = next_rand();
			r   = next_rand();
			sel = r[27:24];
			bus_write(adr_of(`SOC_ID_RAM, int'(a)), sel, wd);
			ram_model[a] = merge_bytes(ram_model[a], wd, sel);
		end
		for (int i = 0; i < 2**`SOC_RAM_AW; i++) begin
			if (ram_valid[i]) begin
				bus_read(adr_of(`SOC_ID_RAM, i), rd);
				check_word($sformatf("ram word %0d", i), ram_model[i], rd);
			end
		end

		bus_write(adr_of(`SOC_ID_GPIO, 5), 4'hF, 32'hA5C3_5A96);
		check_word("gpio pins", 32'h96, soc_bus_pkg::word_t'(gpio_o));
		bus_read(adr_of(`SOC_ID_GPIO, 0), rd);
		check_word("gpio readback", 32'h96, rd);
		bus_write(adr_of(`SOC_ID_GPIO, 0), 4'b1110, 32'h0000_0011);   // lane 0 off
		check_word("gpio without lane 0", 32'h96, soc_bus_pkg::word_t'(gpio_o));

		bus_write(adr_of(`SOC_ID_EXT, 0), 4'hF, 32'h2);
		bus_write(adr_of(`SOC_ID_INTC, 0), 4'hF, 32'h2);
		check_word("sys_int before edge", '0, soc_bus_pkg::word_t'(sys_int_o));
		@(negedge clk);
		ext_int_i = 3'b010;
		repeat (3) @(negedge clk);
		ext_int_i = '0;
		wait_sys_int("external interrupt");
		bus_read(adr_of(`SOC_ID_EXT, 1), rd);
		check_word("ext pending", 32'h2, rd);
		bus_read(adr_of(`SOC_ID_INTC, 1), rd);
		check_word("intc raw lines", 32'h2, rd);
		bus_write(adr_of(`SOC_ID_EXT, 1), 4'hF, 32'h2);
		check_word("sys_int after pending clear", '0, soc_bus_pkg::word_t'(sys_int_o));

		bus_write(adr_of(`SOC_ID_INTC, 0), 4'hF, 32'h1);
		bus_write(adr_of(`SOC_ID_TIMER, 1), 4'hF, 32'd20);
		bus_write(adr_of(`SOC_ID_TIMER, 0), 4'hF, 32'h3);   // run and irq enable
		wait_sys_int("timer");
		bus_read(adr_of(`SOC_ID_TIMER, 3), rd);
		check_word("timer flag", 32'h1, rd);
		bus_write(adr_of(`SOC_ID_TIMER, 3), 4'hF, 32'h1);
		check_word("sys_int after flag clear", '0, soc_bus_pkg::word_t'(sys_int_o));
		bus_read(adr_of(`SOC_ID_TIMER, 2), rd);
		checks++;
		assert (rd <= 32'd20)
		else begin
			errors++;
			$display("Error timer count: expected <= 20, actual %0d", rd);
		end
		bus_write(adr_of(`SOC_ID_TIMER, 0), 4'hF, 32'h0);

		bus_write(adr_of(`SOC_ID_RAM, 0), 4'hF, 32'h1234_5678);
		bus_read(adr_of(6, 0), rd);
		check_word("unmapped read", '0, rd);
		bus_write(adr_of(6, 0), 4'hF, 32'hDEAD_BEEF);
		bus_read(adr_of(`SOC_ID_RAM, 0), rd);
		check_word("ram word 0 after unmapped write", 32'h1234_5678, rd);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* src.f */
+incdir+.
soc_bus_pkg.sv
soc_periph_pkg.sv
soc_interconnect.sv
soc_ram.sv
soc_gpio.sv
soc_timer.sv
soc_ext_int.sv
soc_int_ctrl.sv
soc_top.sv
tb_soc.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_soc
FILELIST  := src.f
BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
SRCS      := $(filter-out +incdir+%,$(shell cat $(FILELIST))) soc_cfg.svh

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf $(BUILD_DIR)
